// ==== Bender.yml ====
package:
  name: datapath

sources:
  - files:
      - src/cpuPkg.sv
      - src/busPkg.sv
      - src/busIf.sv
      - src/busArbiter.sv
      - src/regFile.sv
      - src/aluUnit.sv
      - src/controlRegs.sv
      - src/memInterface.sv
      - src/datapath.sv
  - target: test
    files:
      - verification/datapathTb.sv

// ==== filelist.f ====
src/cpuPkg.sv
src/busPkg.sv
src/busIf.sv
src/busArbiter.sv
src/regFile.sv
src/aluUnit.sv
src/controlRegs.sv
src/memInterface.sv
src/datapath.sv
verification/datapathTb.sv

// ==== src/aluUnit.sv ====
module aluUnit (
  input logic clock,
  input logic arstN,
  input cpuPkg::aluOp_e opcode,
  input logic yIn,
  input logic zIn,
  input logic incPc,
  input logic zHighOut,
  input logic zLowOut,
  busIf.peer bus
);

  logic [cpuPkg::wordWidth-1:0] y;
  logic [2*cpuPkg::wordWidth-1:0] z;
  logic [2*cpuPkg::wordWidth-1:0] result;
  logic [2*cpuPkg::wordWidth-1:0] product;
  logic [2*cpuPkg::wordWidth-1:0] rorWide;
  logic [2*cpuPkg::wordWidth-1:0] rolWide;
  logic [cpuPkg::wordWidth-1:0] narrow;
  logic [cpuPkg::wordWidth-1:0] incremented;
  logic [cpuPkg::wordWidth-1:0] quotient;
  logic [cpuPkg::wordWidth-1:0] remainder;
  logic [$clog2(cpuPkg::wordWidth)-1:0] shamt;

  assign shamt = bus.busData[$clog2(cpuPkg::wordWidth)-1:0];
  assign rorWide = {y, y} >> shamt;  // Rotates from a doubled copy of Y.
  assign rolWide = {y, y} << shamt;
  assign product = $signed(y) * $signed(bus.busData);
  assign incremented = bus.busData + 1'b1;

  always_comb begin
    quotient = '0;
    remainder = '0;
    if (bus.busData != '0) begin
      quotient = $signed(y) / $signed(bus.busData);
      remainder = $signed(y) % $signed(bus.busData);
    end
  end

  // Neg and not use the bus alone.
  always_comb begin
    case (opcode)
      cpuPkg::opAdd: narrow = y + bus.busData;
      cpuPkg::opSub: narrow = y - bus.busData;
      cpuPkg::opAnd: narrow = y & bus.busData;
      cpuPkg::opOr: narrow = y | bus.busData;
      cpuPkg::opShr: narrow = y >> shamt;
      cpuPkg::opShra: narrow = $signed(y) >>> shamt;
      cpuPkg::opShl: narrow = y << shamt;
      cpuPkg::opRor: narrow = rorWide[cpuPkg::wordWidth-1:0];
      cpuPkg::opRol: narrow = rolWide[2*cpuPkg::wordWidth-1:cpuPkg::wordWidth];
      cpuPkg::opNeg: narrow = -bus.busData;
      cpuPkg::opNot: narrow = ~bus.busData;
      default: narrow = '0;
    endcase
  end

  always_comb begin
    if (incPc) begin
      result = {{cpuPkg::wordWidth{incremented[cpuPkg::wordWidth-1]}}, incremented};
    end else if (opcode == cpuPkg::opMul) begin
      result = product;
    end else if (opcode == cpuPkg::opDiv) begin
      result = {remainder, quotient};
    end else begin
      result = {{cpuPkg::wordWidth{narrow[cpuPkg::wordWidth-1]}}, narrow};
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      y <= '0;
      z <= '0;
    end else begin
      if (yIn) begin
        y <= bus.busData;
      end
      if (zIn) begin
        z <= result;
      end
    end
  end

  assign bus.outReq[busPkg::srcZHigh] = zHighOut;
  assign bus.srcData[busPkg::srcZHigh] = z[2*cpuPkg::wordWidth-1:cpuPkg::wordWidth];
  assign bus.outReq[busPkg::srcZLow] = zLowOut;
  assign bus.srcData[busPkg::srcZLow] = z[cpuPkg::wordWidth-1:0];

endmodule

// ==== src/busArbiter.sv ====
module busArbiter (
  input logic clock,
  input logic arstN,
  busIf.arbiter bus
);

  busPkg::busSrc_e winner;

  always_comb begin
    winner = busPkg::srcR0;
    // Scan down so the lowest active source is the last one kept.
    for (int i = busPkg::numSources - 1; i >= 0; i--) begin
      if (bus.outReq[i]) begin
        winner = busPkg::busSrc_e'(i);
      end
    end
  end

  assign bus.busValid = |bus.outReq;
  assign bus.busData = bus.busValid ? bus.srcData[winner] : '0;  // Idle bus reads zero.

  // The control sequence gives the bus to one peer per cycle.
  singleDriver: assert property (
    @(posedge clock) disable iff (!arstN)
      $onehot0(bus.outReq)
  ) else $error("Bus driven by more than one source, outReq %b.", bus.outReq);

endmodule

// ==== src/busIf.sv ====
interface busIf;

  logic [busPkg::numSources-1:0] outReq;  // One out strobe per source.
  logic [cpuPkg::wordWidth-1:0] srcData [busPkg::numSources];
  logic [cpuPkg::wordWidth-1:0] busData;
  logic busValid;

  modport arbiter (
    input outReq,
    input srcData,
    output busData,
    output busValid
  );

  modport peer (
    output outReq,
    output srcData,
    input busData
  );

  modport sink (input busData, input busValid);

endinterface

// ==== src/busPkg.sv ====
package busPkg;

  // General registers first, then eight special sources.
  localparam int numSources = cpuPkg::numRegs + 8;
  localparam int srcSelWidth = $clog2(numSources);

  // IR bits that form the sign-extended constant.
  localparam int constWidth = 19;

  // Listed in priority order, lowest value wins.
  typedef enum logic [srcSelWidth-1:0] {
    srcR0, srcR1, srcR2, srcR3,
    srcR4, srcR5, srcR6, srcR7,
    srcR8, srcR9, srcR10, srcR11,
    srcR12, srcR13, srcR14, srcR15,
    srcHi,
    srcLo,
    srcZHigh,
    srcZLow,
    srcPc,
    srcMdr,
    srcInPort,
    srcConst
  } busSrc_e;

endpackage

// ==== src/controlRegs.sv ====
module controlRegs (
  input logic clock,
  input logic arstN,
  input logic pcIn,
  input logic pcOut,
  input logic irIn,
  input logic hiIn,
  input logic hiOut,
  input logic loIn,
  input logic loOut,
  input logic cOut,
  output logic [cpuPkg::wordWidth-1:0] ir,
  busIf.peer bus
);

  logic [cpuPkg::wordWidth-1:0] pc;
  logic [cpuPkg::wordWidth-1:0] hi;
  logic [cpuPkg::wordWidth-1:0] lo;
  logic [cpuPkg::wordWidth-1:0] constant;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
      ir <= '0;
      hi <= '0;
      lo <= '0;
    end else begin
      if (pcIn) begin
        pc <= bus.busData;
      end
      if (irIn) begin
        ir <= bus.busData;
      end
      if (hiIn) begin
        hi <= bus.busData;
      end
      if (loIn) begin
        lo <= bus.busData;
      end
    end
  end

  // Immediate field, sign-extended.
  assign constant = {{(cpuPkg::wordWidth - busPkg::constWidth){ir[busPkg::constWidth-1]}},
                     ir[busPkg::constWidth-1:0]};

  assign bus.outReq[busPkg::srcPc] = pcOut;
  assign bus.srcData[busPkg::srcPc] = pc;
  assign bus.outReq[busPkg::srcHi] = hiOut;
  assign bus.srcData[busPkg::srcHi] = hi;
  assign bus.outReq[busPkg::srcLo] = loOut;
  assign bus.srcData[busPkg::srcLo] = lo;
  assign bus.outReq[busPkg::srcConst] = cOut;
  assign bus.srcData[busPkg::srcConst] = constant;

endmodule

// ==== src/cpuPkg.sv ====
package cpuPkg;

  localparam int wordWidth = 32;
  localparam int numRegs = 16;
  localparam int regFieldWidth = $clog2(numRegs);

  // Register fields in the IR.
  localparam int raLsb = 23;
  localparam int rbLsb = 19;
  localparam int rcLsb = 15;

  typedef enum logic [4:0] {
    opAdd,
    opSub,
    opAnd,
    opOr,
    opShr,
    opShra,
    opShl,
    opRor,
    opRol,
    opMul,
    opDiv,
    opNeg,
    opNot
  } aluOp_e;

endpackage

// ==== src/datapath.sv ====
module datapath (
  input logic clock,
  input logic arstN,
  input logic gra,
  input logic grb,
  input logic grc,
  input logic rIn,
  input logic rOut,
  input logic baOut,
  input logic yIn,
  input logic zIn,
  input logic incPc,
  input logic zHighOut,
  input logic zLowOut,
  input logic pcIn,
  input logic pcOut,
  input logic irIn,
  input logic hiIn,
  input logic hiOut,
  input logic loIn,
  input logic loOut,
  input logic cOut,
  input logic marIn,
  input logic mdrIn,
  input logic mdrOut,
  input logic read,
  input logic inPortOut,
  input logic outPortIn,
  input cpuPkg::aluOp_e opcode,
  input logic [cpuPkg::wordWidth-1:0] mDataIn,
  input logic [cpuPkg::wordWidth-1:0] inPortData,
  output logic [cpuPkg::wordWidth-1:0] busValue,
  output logic busValid,
  output logic [cpuPkg::wordWidth-1:0] memAddr,
  output logic [cpuPkg::wordWidth-1:0] memDataOut,
  output logic [cpuPkg::wordWidth-1:0] outPortData
);

  logic [cpuPkg::wordWidth-1:0] ir;  // Register fields for regFile.

  busIf busLink ();

  busArbiter i_busArbiter (
    .clock(clock),
    .arstN(arstN),
    .bus(busLink.arbiter)
  );

  regFile i_regFile (
    .clock(clock),
    .arstN(arstN),
    .ir(ir),
    .gra(gra),
    .grb(grb),
    .grc(grc),
    .rIn(rIn),
    .rOut(rOut),
    .baOut(baOut),
    .bus(busLink.peer)
  );

  aluUnit i_aluUnit (
    .clock(clock),
    .arstN(arstN),
    .opcode(opcode),
    .yIn(yIn),
    .zIn(zIn),
    .incPc(incPc),
    .zHighOut(zHighOut),
    .zLowOut(zLowOut),
    .bus(busLink.peer)
  );

  controlRegs i_controlRegs (
    .clock(clock),
    .arstN(arstN),
    .pcIn(pcIn),
    .pcOut(pcOut),
    .irIn(irIn),
    .hiIn(hiIn),
    .hiOut(hiOut),
    .loIn(loIn),
    .loOut(loOut),
    .cOut(cOut),
    .ir(ir),
    .bus(busLink.peer)
  );

  memInterface i_memInterface (
    .clock(clock),
    .arstN(arstN),
    .marIn(marIn),
    .mdrIn(mdrIn),
    .mdrOut(mdrOut),
    .read(read),
    .inPortOut(inPortOut),
    .outPortIn(outPortIn),
    .mDataIn(mDataIn),
    .inPortData(inPortData),
    .memAddr(memAddr),
    .memDataOut(memDataOut),
    .outPortData(outPortData),
    .bus(busLink.peer)
  );

  // Bus value as seen by any sink.
  assign busValue = busLink.busData;
  assign busValid = busLink.busValid;

endmodule

// ==== src/memInterface.sv ====
module memInterface (
  input logic clock,
  input logic arstN,
  input logic marIn,
  input logic mdrIn,
  input logic mdrOut,
  input logic read,
  input logic inPortOut,
  input logic outPortIn,
  input logic [cpuPkg::wordWidth-1:0] mDataIn,
  input logic [cpuPkg::wordWidth-1:0] inPortData,
  output logic [cpuPkg::wordWidth-1:0] memAddr,
  output logic [cpuPkg::wordWidth-1:0] memDataOut,
  output logic [cpuPkg::wordWidth-1:0] outPortData,
  busIf.peer bus
);

  logic [cpuPkg::wordWidth-1:0] mdrNext;
  logic [cpuPkg::wordWidth-1:0] inPort;

  assign mdrNext = read ? mDataIn : bus.busData;  // Memory data on a read.

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      memAddr <= '0;
      memDataOut <= '0;
      inPort <= '0;
      outPortData <= '0;
    end else begin
      inPort <= inPortData;  // Sampled every cycle.
      if (marIn) begin
        memAddr <= bus.busData;
      end
      if (mdrIn) begin
        memDataOut <= mdrNext;
      end
      if (outPortIn) begin
        outPortData <= bus.busData;
      end
    end
  end

  assign bus.outReq[busPkg::srcMdr] = mdrOut;
  assign bus.srcData[busPkg::srcMdr] = memDataOut;
  assign bus.outReq[busPkg::srcInPort] = inPortOut;
  assign bus.srcData[busPkg::srcInPort] = inPort;

endmodule

// ==== src/regFile.sv ====
module regFile (
  input logic clock,
  input logic arstN,
  input logic [cpuPkg::wordWidth-1:0] ir,
  input logic gra,
  input logic grb,
  input logic grc,
  input logic rIn,
  input logic rOut,
  input logic baOut,
  busIf.peer bus
);

  logic [cpuPkg::regFieldWidth-1:0] field;
  logic [cpuPkg::numRegs-1:0] regSel;
  logic [cpuPkg::wordWidth-1:0] regs [cpuPkg::numRegs];

  // Pick ra, rb or rc from the IR.
  assign field =
      ({cpuPkg::regFieldWidth{gra}} & ir[cpuPkg::raLsb +: cpuPkg::regFieldWidth])
    | ({cpuPkg::regFieldWidth{grb}} & ir[cpuPkg::rbLsb +: cpuPkg::regFieldWidth])
    | ({cpuPkg::regFieldWidth{grc}} & ir[cpuPkg::rcLsb +: cpuPkg::regFieldWidth]);

  always_comb begin
    regSel = '0;
    regSel[field] = 1'b1;
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < cpuPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (rIn) begin
      regs[field] <= bus.busData;
    end
  end

  for (genvar i = 0; i < cpuPkg::numRegs; i++) begin : gPeer
    assign bus.outReq[busPkg::srcR0 + i] = regSel[i] & (rOut | baOut);
    if (i == 0) begin : gBase
      assign bus.srcData[busPkg::srcR0] = baOut ? '0 : regs[0];  // Zero base address.
    end else begin : gReg
      assign bus.srcData[busPkg::srcR0 + i] = regs[i];
    end
  end

  // A register strobe needs exactly one IR field behind it.
  oneFieldSelect: assert property (
    @(posedge clock) disable iff (!arstN)
      (rIn || rOut || baOut) |-> $onehot({gra, grb, grc})
  ) else $error("Register strobe without exactly one of gra, grb, grc.");

endmodule

// ==== verification/datapathTb.sv ====
module datapathTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam time halfPeriod = 20ns;
  localparam int resetCycles = 3;
  localparam int seed = 60;
  localparam string vectorFile = "verification/datapathVectors.txt";
  localparam logic [31:0] outStrobes = 32'h00A6_9630;  // Every strobe that asks for the bus.
  localparam logic [31:0] mdrOutStrobe = 32'h0020_0000;

  typedef struct packed {
    logic [31:0] strobes;
    logic [4:0] op;
    logic [31:0] mData;
    logic [31:0] inData;
    logic [31:0] expBus;
    logic [3:0] flags;  // Bus, outPortData, memAddr, random inPortData.
    logic [31:0] expOut;
    logic [31:0] expAddr;
  } vector_t;

  logic clock = 1'b0;
  logic arstN;
  logic gra, grb, grc, rIn, rOut, baOut, yIn, zIn, incPc, zHighOut, zLowOut;
  logic pcIn, pcOut, irIn, hiIn, hiOut, loIn, loOut, cOut;
  logic marIn, mdrIn, mdrOut, read, inPortOut, outPortIn;
  cpuPkg::aluOp_e opcode;
  logic [31:0] mDataIn;
  logic [31:0] inPortData;
  logic [31:0] busValue;
  logic busValid;
  logic [31:0] memAddr;
  logic [31:0] memDataOut;
  logic [31:0] outPortData;

  vector_t vectors[$];
  logic vectorsLoaded = 1'b0;

  datapath i_datapath (.*);

  always #(halfPeriod) clock = ~clock;

  task automatic driveStrobes(input logic [24:0] s);
    {outPortIn, inPortOut, read, mdrOut, mdrIn, marIn, cOut, loOut, loIn, hiOut, hiIn, irIn,
     pcOut, pcIn, zLowOut, zHighOut, incPc, zIn, yIn, baOut, rOut, rIn, grc, grb, gra} = s;
  endtask

  function automatic logic expectBusValid(input logic [31:0] s);
    return |(s & outStrobes);
  endfunction

  task automatic readVectors();
    int fd;
    int count;
    string line;
    logic [31:0] fields [8];
    vector_t v;
    fd = $fopen(vectorFile, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s.", vectorFile);
      $display("SOME TESTS FAILED");
      $fatal(1, "Missing vector file.");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.substr(0, 1) != "//") begin
        count = $sscanf(line, "%h %h %h %h %h %h %h %h", fields[0], fields[1], fields[2],
                        fields[3], fields[4], fields[5], fields[6], fields[7]);
        if (count == 8) begin
          v = {fields[0], fields[1][4:0], fields[2], fields[3], fields[4], fields[5][3:0],
               fields[6], fields[7]};
          vectors.push_back(v);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic applyVector(input vector_t v);
    driveStrobes(v.strobes[24:0]);
    opcode = cpuPkg::aluOp_e'(v.op);
    mDataIn = v.mData;
    inPortData = v.flags[3] ? $urandom() : v.inData;  // Never read back.
  endtask

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic checkVector(input vector_t v);
    if (v.flags[0]) begin
      compareValue("busValue", busValue, v.expBus);
      compareValue("busValid", busValid, expectBusValid(v.strobes));
      if ((v.strobes & outStrobes) == mdrOutStrobe) begin
        compareValue("memDataOut", memDataOut, v.expBus);  // MDR alone on the bus.
      end
    end
    if (v.flags[1]) begin
      compareValue("outPortData", outPortData, v.expOut);
    end
    if (v.flags[2]) begin
      compareValue("memAddr", memAddr, v.expAddr);
    end
  endtask

  initial begin
    arstN = 1'b0;
    driveStrobes('0);
    opcode = cpuPkg::opAdd;
    mDataIn = '0;
    inPortData = '0;
    void'($urandom(seed));
    readVectors();
    if (vectors.size() == 0) begin
      $display("The vector file holds no usable lines.");
      $display("SOME TESTS FAILED");
      $fatal(1, "No vectors.");
    end
    vectorsLoaded = 1'b1;
    repeat (resetCycles) @(posedge clock);
    @(negedge clock);
    arstN = 1'b1;
    foreach (vectors[i]) begin
      @(negedge clock);
      applyVector(vectors[i]);
      #(halfPeriod - 1ns);  // Just ahead of the loading edge.
      checkVector(vectors[i]);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Two cycles per line of slack.
  initial begin
    wait (vectorsLoaded);
    #((vectors.size() + 10) * 80ns);
    $display("Timed out at %0t before all vectors were applied.", $time);
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired.");
  end

endmodule

// ==== verification/datapathVectors.txt ====
// strobes op mDataIn inPortData expBus flags expOutPort expMemAddr, all hex
// flags: bit0 bus and busValid, bit1 outPortData, bit2 memAddr, bit3 random inPortData
0000000 0 00000000 00000000 00000000 7 00000000 00000000
0000011 0 00000000 00000000 00000000 1 00000000 00000000
0008000 0 00000000 00000000 00000000 1 00000000 00000000
0020000 0 00000000 00000000 00000000 1 00000000 00000000
0000200 0 00000000 00000000 00000000 1 00000000 00000000
0000400 0 00000000 00000000 00000000 1 00000000 00000000
0001000 0 00000000 00000000 00000000 1 00000000 00000000
0200000 0 00000000 00000000 00000000 1 00000000 00000000
0040000 0 00000000 00000000 00000000 1 00000000 00000000
0800000 0 00000000 01A81234 00000000 1 00000000 00000000
0802000 0 00000000 89ABCDEF 01A81234 1 00000000 00000000
0800009 0 00000000 00000055 89ABCDEF 1 00000000 00000000
080000A 0 00000000 0BADF00D 00000055 1 00000000 00000000
080000C 0 00000000 00000000 0BADF00D 9 00000000 00000000
0000011 0 00000000 00000000 89ABCDEF 9 00000000 00000000
0000012 0 00000000 00000000 00000055 9 00000000 00000000
0000014 0 00000000 00000000 0BADF00D 9 00000000 00000000
0000024 0 00000000 00000000 00000000 9 00000000 00000000
0000051 0 00000000 0F0F0F0F 89ABCDEF 1 00000000 00000000
0800080 0 00000000 0F0F0F0F 0F0F0F0F 1 00000000 00000000
0000400 0 00000000 0F0F0F0F 98BADCFE 1 00000000 00000000
0000200 0 00000000 0F0F0F0F FFFFFFFF 1 00000000 00000000
0800080 1 00000000 0F0F0F0F 0F0F0F0F 1 00000000 00000000
0000400 0 00000000 0F0F0F0F 7A9CBEE0 1 00000000 00000000
0000200 0 00000000 0F0F0F0F 00000000 1 00000000 00000000
0800080 2 00000000 0F0F0F0F 0F0F0F0F 1 00000000 00000000
0000400 0 00000000 0F0F0F0F 090B0D0F 1 00000000 00000000
0800080 3 00000000 0F0F0F0F 0F0F0F0F 1 00000000 00000000
0000400 0 00000000 00000028 8FAFCFEF 1 00000000 00000000
0800080 4 00000000 00000028 00000028 1 00000000 00000000
0000400 0 00000000 00000028 0089ABCD 1 00000000 00000000
0800080 5 00000000 00000028 00000028 1 00000000 00000000
0000400 0 00000000 00000028 FF89ABCD 1 00000000 00000000
0800080 6 00000000 00000028 00000028 1 00000000 00000000
0000400 0 00000000 00000028 ABCDEF00 1 00000000 00000000
0800080 7 00000000 00000028 00000028 1 00000000 00000000
0000400 0 00000000 00000028 EF89ABCD 1 00000000 00000000
0800080 8 00000000 00000028 00000028 1 00000000 00000000
0000400 0 00000000 00000028 ABCDEF89 1 00000000 00000000
0800080 B 00000000 00000028 00000028 1 00000000 00000000
0000400 0 00000000 00000028 FFFFFFD8 1 00000000 00000000
0800080 C 00000000 00000028 00000028 1 00000000 00000000
0000400 0 00000000 80000000 FFFFFFD7 1 00000000 00000000
0800040 0 00000000 00000007 80000000 1 00000000 00000000
0800080 9 00000000 00000007 00000007 1 00000000 00000000
0000400 0 00000000 00000007 80000000 1 00000000 00000000
0000200 0 00000000 00000007 FFFFFFFC 1 00000000 00000000
0800080 A 00000000 00000007 00000007 1 00000000 00000000
0000400 0 00000000 00000007 EDB6DB6E 1 00000000 00000000
0000200 0 00000000 00000007 FFFFFFFE 1 00000000 00000000
00000A4 A 00000000 00000000 00000000 1 00000000 00000000
0000400 0 00000000 00000000 00000000 1 00000000 00000000
0000200 0 00000000 0000FFFF 00000000 1 00000000 00000000
0800800 0 00000000 00000000 0000FFFF 1 00000000 00000000
0001180 1 00000000 00000000 0000FFFF 1 00000000 00000000
0000C00 0 00000000 00000000 00010000 1 00000000 00000000
0001000 0 00000000 00000000 00010000 1 00000000 00000000
0500000 0 13579BDF 00000000 00000000 1 00000000 00000000
0280000 0 00000000 00000000 13579BDF 1 00000000 00000000
1200000 0 00000000 00000000 13579BDF 5 00000000 13579BDF
0000000 0 00000000 00000000 00000000 7 13579BDF 13579BDF
0100011 0 DEADBEEF 00000000 89ABCDEF 1 00000000 00000000
0200000 0 00000000 2468ACE0 89ABCDEF 1 00000000 00000000
0800000 0 00000000 FFF3FFFF 2468ACE0 1 00000000 00000000
0802000 0 00000000 00040005 FFF3FFFF 1 00000000 00000000
0040000 0 00000000 00040005 0003FFFF 1 00000000 00000000
0802000 0 00000000 00000000 00040005 1 00000000 00000000
0040000 0 00000000 00000000 FFFC0005 1 00000000 00000000
